//--- rv_core_defs.svh
/*
 * Reset PC, major opcode values and register count for the RV32I core
 */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

`define RV_RESET_PC   32'h0000_0000

// RV32I major opcodes, inst[6:0]
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

`define RV_NUM_REGS   32

`endif

//--- rv_core_pkg.sv
/*
 * Core types: word, register index and funct3 vectors, ALU and select enums,
 * instruction field, control and data bus request structs
 */
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  // Also the load/store data format
  typedef logic [2:0]  funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_func_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS_4} wb_sel_e;

  typedef enum logic [1:0] {PC_PLUS_4, PC_BRANCH_TARGET, PC_JALR_TARGET} pc_sel_e;

  // Field order matches the R-type layout, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    funct3_t    funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } inst_fields_t;

  typedef struct packed {
    alu_func_e alu_func;
    logic      op_a_pc;
    logic      op_b_imm;
    logic      reg_we;
    wb_sel_e   wb_sel;
    pc_sel_e   pc_sel;
  } ctl_t;

  typedef struct packed {
    word_t      address;
    word_t      write_data;
    logic [3:0] byte_enable;
    logic       write_enable;
    logic       read_enable;
  } dmem_req_t;

endpackage

//--- rv_regfile.sv
/*
 * Register file, two combinational read ports and one write port,
 * x0 hardwired to zero
 */
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_regfile import rv_core_pkg::*; #(
  parameter int num_regs = `RV_NUM_REGS
) (
  input  logic     clock,
  input  reg_idx_t rd_idx,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  input  word_t    rd_data,
  input  logic     we,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [num_regs];

  always_ff @(posedge clock) begin
    if (we && rd_idx != '0) begin
      regs[rd_idx] <= rd_data;
    end
  end

  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- rv_alu.sv
/*
 * RV32I ALU with operand compare flags for branch decisions
 */
`timescale 1ns/100ps

module rv_alu import rv_core_pkg::*; (
  input  alu_func_e func,
  input  word_t     op_a,
  input  word_t     op_b,
  output word_t     result,
  output logic      eq,
  output logic      lt,
  output logic      ltu
);

  logic [4:0] shamt;

  assign shamt = op_b[4:0];

  // Compares use the raw operands
  assign eq  = (op_a == op_b);
  assign lt  = ($signed(op_a) < $signed(op_b));
  assign ltu = (op_a < op_b);

  always_comb begin
    unique case (func)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {31'b0, lt};
      ALU_SLTU:   result = {31'b0, ltu};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      // LUI just forwards the U immediate
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

endmodule

//--- rv_datapath.sv
/*
 * Datapath: PC register, field and immediate decode, operand and
 * write-back muxes, next-PC selection, register file and ALU
 */
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_datapath import rv_core_pkg::*; (
  input  logic         clock,
  input  logic         rst_n,
  input  word_t        inst,
  input  ctl_t         ctl,
  input  word_t        mem_read_data,
  output inst_fields_t fields,
  output word_t        alu_result,
  output word_t        rs2_data,
  output logic         eq,
  output logic         lt,
  output logic         ltu,
  output word_t        pc
);

  word_t imm;
  word_t rs1_data;
  word_t op_a;
  word_t op_b;
  word_t wb_data;
  word_t pc_plus_4;
  word_t branch_target;
  word_t jalr_target;
  word_t next_pc;

  assign fields = inst_fields_t'(inst);

  // Immediate format follows the opcode
  always_comb begin
    case (fields.opcode)
      `RV_OP_LUI, `RV_OP_AUIPC: imm = {inst[31:12], 12'b0};
      `RV_OP_JAL:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      `RV_OP_BRANCH: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      `RV_OP_STORE:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      default:       imm = {{20{inst[31]}}, inst[31:20]};
    endcase
  end

  rv_regfile #(
    .num_regs(`RV_NUM_REGS)
  ) u_regfile (
    .clock    (clock),
    .rd_idx   (fields.rd),
    .rs1_idx  (fields.rs1),
    .rs2_idx  (fields.rs2),
    .rd_data  (wb_data),
    .we       (ctl.reg_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign op_a = ctl.op_a_pc  ? pc  : rs1_data;
  assign op_b = ctl.op_b_imm ? imm : rs2_data;

  rv_alu u_alu (
    .func   (ctl.alu_func),
    .op_a   (op_a),
    .op_b   (op_b),
    .result (alu_result),
    .eq     (eq),
    .lt     (lt),
    .ltu    (ltu)
  );

  assign pc_plus_4 = pc + 32'd4;
  // Own adder, the ALU is busy comparing rs1 with rs2 on branches
  assign branch_target = pc + imm;
  // ALU forms rs1 + imm for JALR
  assign jalr_target = {alu_result[31:1], 1'b0};

  always_comb begin
    unique case (ctl.wb_sel)
      WB_MEM:       wb_data = mem_read_data;
      WB_PC_PLUS_4: wb_data = pc_plus_4;
      default:      wb_data = alu_result;
    endcase
  end

  always_comb begin
    unique case (ctl.pc_sel)
      PC_BRANCH_TARGET: next_pc = branch_target;
      PC_JALR_TARGET:   next_pc = jalr_target;
      default:          next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

//--- rv_ctlpath.sv
/*
 * Control path: opcode/funct decode into control fields and ALU function,
 * branch condition, memory enables gated in reset
 */
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_ctlpath import rv_core_pkg::*; (
  input  logic         rst_n,
  input  inst_fields_t fields,
  input  logic         eq,
  input  logic         lt,
  input  logic         ltu,
  output ctl_t         ctl,
  output logic         mem_read_enable,
  output logic         mem_write_enable
);

  logic      is_reg_op;
  logic      branch_taken;
  alu_func_e op_func;

  assign is_reg_op = (fields.opcode == `RV_OP_REG);

  // BEQ BNE BLT BGE BLTU BGEU
  always_comb begin
    case (fields.funct3)
      3'b000:  branch_taken = eq;
      3'b001:  branch_taken = !eq;
      3'b100:  branch_taken = lt;
      3'b101:  branch_taken = !lt;
      3'b110:  branch_taken = ltu;
      3'b111:  branch_taken = !ltu;
      default: branch_taken = 1'b0;
    endcase
  end

  // Shared by OP and OP-IMM, SUB only exists in register form
  always_comb begin
    unique case (fields.funct3)
      3'b000:  op_func = (is_reg_op && fields.funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  op_func = ALU_SLL;
      3'b010:  op_func = ALU_SLT;
      3'b011:  op_func = ALU_SLTU;
      3'b100:  op_func = ALU_XOR;
      3'b101:  op_func = fields.funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  op_func = ALU_OR;
      default: op_func = ALU_AND;
    endcase
  end

  always_comb begin
    ctl.alu_func     = ALU_ADD;
    ctl.op_a_pc      = 1'b0;
    ctl.op_b_imm     = 1'b1;
    ctl.reg_we       = 1'b0;
    ctl.wb_sel       = WB_ALU;
    ctl.pc_sel       = PC_PLUS_4;
    mem_read_enable  = 1'b0;
    mem_write_enable = 1'b0;
    case (fields.opcode)
      `RV_OP_LUI: begin
        ctl.alu_func = ALU_PASS_B;
        ctl.reg_we   = 1'b1;
      end
      `RV_OP_AUIPC: begin
        ctl.op_a_pc = 1'b1;
        ctl.reg_we  = 1'b1;
      end
      `RV_OP_JAL: begin
        ctl.op_a_pc = 1'b1;
        ctl.reg_we  = 1'b1;
        ctl.wb_sel  = WB_PC_PLUS_4;
        ctl.pc_sel  = PC_BRANCH_TARGET;
      end
      `RV_OP_JALR: begin
        ctl.reg_we = 1'b1;
        ctl.wb_sel = WB_PC_PLUS_4;
        ctl.pc_sel = PC_JALR_TARGET;
      end
      `RV_OP_BRANCH: begin
        // rs1 against rs2 in the ALU
        ctl.alu_func = ALU_SUB;
        ctl.op_b_imm = 1'b0;
        ctl.pc_sel   = branch_taken ? PC_BRANCH_TARGET : PC_PLUS_4;
      end
      `RV_OP_LOAD: begin
        ctl.reg_we      = 1'b1;
        ctl.wb_sel      = WB_MEM;
        mem_read_enable = 1'b1;
      end
      `RV_OP_STORE: mem_write_enable = 1'b1;
      `RV_OP_IMM: begin
        ctl.alu_func = op_func;
        ctl.reg_we   = 1'b1;
      end
      `RV_OP_REG: begin
        ctl.alu_func = op_func;
        ctl.op_b_imm = 1'b0;
        ctl.reg_we   = 1'b1;
      end
      default: ;  // unknown opcode, just step the PC
    endcase
    // No state or memory changes while in reset
    if (!rst_n) begin
      ctl.reg_we       = 1'b0;
      ctl.pc_sel       = PC_PLUS_4;
      mem_read_enable  = 1'b0;
      mem_write_enable = 1'b0;
    end
  end

endmodule

//--- rv_dmem_interface.sv
/*
 * Data memory interface: store lane replication and byte enables,
 * load lane extraction with sign or zero extension
 */
`timescale 1ns/100ps

module rv_dmem_interface import rv_core_pkg::*; (
  input  word_t     address,
  input  funct3_t   data_format,
  input  word_t     write_data,
  input  word_t     bus_read_data,
  input  logic      write_enable,
  input  logic      read_enable,
  output dmem_req_t bus_req,
  output word_t     read_data
);

  logic [1:0] offset;
  word_t      lane_data;

  assign offset = address[1:0];

  assign bus_req.address      = address;
  assign bus_req.write_enable = write_enable;
  assign bus_req.read_enable  = read_enable;

  // funct3[1:0] gives the size, funct3[2] the unsigned flag on loads
  always_comb begin
    case (data_format[1:0])
      2'b00: begin
        bus_req.write_data  = {4{write_data[7:0]}};
        bus_req.byte_enable = 4'b0001 << offset;
      end
      2'b01: begin
        bus_req.write_data  = {2{write_data[15:0]}};
        bus_req.byte_enable = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        bus_req.write_data  = write_data;
        bus_req.byte_enable = 4'b1111;
      end
    endcase
  end

  assign lane_data = bus_read_data >> {offset, 3'b000};

  always_comb begin
    case (data_format)
      3'b000:  read_data = {{24{lane_data[7]}}, lane_data[7:0]};
      3'b001:  read_data = {{16{lane_data[15]}}, lane_data[15:0]};
      3'b100:  read_data = {24'b0, lane_data[7:0]};
      3'b101:  read_data = {16'b0, lane_data[15:0]};
      default: read_data = bus_read_data;
    endcase
  end

endmodule

//--- riscv_core.sv
/*
 * Single-cycle RV32I core top: control path, datapath, data memory interface
 */
`timescale 1ns/100ps

module riscv_core import rv_core_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  input  word_t     inst,
  input  word_t     bus_read_data,
  output word_t     pc,
  output dmem_req_t bus_req
);

  inst_fields_t fields;
  ctl_t         ctl;
  word_t        alu_result;
  word_t        rs2_data;
  word_t        load_data;
  logic         eq;
  logic         lt;
  logic         ltu;
  logic         mem_read_enable;
  logic         mem_write_enable;

  rv_datapath u_datapath (
    .clock         (clock),
    .rst_n         (rst_n),
    .inst          (inst),
    .ctl           (ctl),
    .mem_read_data (load_data),
    .fields        (fields),
    .alu_result    (alu_result),
    .rs2_data      (rs2_data),
    .eq            (eq),
    .lt            (lt),
    .ltu           (ltu),
    .pc            (pc)
  );

  rv_ctlpath u_ctlpath (
    .rst_n            (rst_n),
    .fields           (fields),
    .eq               (eq),
    .lt               (lt),
    .ltu              (ltu),
    .ctl              (ctl),
    .mem_read_enable  (mem_read_enable),
    .mem_write_enable (mem_write_enable)
  );

  // ALU result is the load/store address
  rv_dmem_interface u_dmem (
    .address       (alu_result),
    .data_format   (fields.funct3),
    .write_data    (rs2_data),
    .bus_read_data (bus_read_data),
    .write_enable  (mem_write_enable),
    .read_enable   (mem_read_enable),
    .bus_req       (bus_req),
    .read_data     (load_data)
  );

endmodule

//--- tb_core_checker.sv
/*
 * Instruction-set model of the RV32I core, stepped once per cycle,
 * compares pc and the data bus request with the DUT
 */
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module tb_core_checker import rv_core_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  input  word_t     inst,
  input  word_t     pc,
  input  dmem_req_t bus_req,
  output int        errors,
  output int        steps
);

  word_t model_pc;
  word_t regs [32];
  word_t mem [1024];
  int    mismatches = 0;
  int    executed = 0;

  assign errors = mismatches;
  assign steps  = executed;

  function automatic word_t fill_word(input int idx);
    return (word_t'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic word_t merge_lanes(input word_t old, input word_t data, input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        old[8*b +: 8] = data[8*b +: 8];
      end
    end
    return old;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // alt selects SUB or SRA
  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return word_t'($signed(a) < $signed(b));
      3'b011:  return word_t'(a < b);
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      mismatches++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic step_model();
    word_t      rs1v;
    word_t      rs2v;
    word_t      imm_i;
    word_t      result;
    word_t      exp_addr;
    word_t      next_pc;
    word_t      lane;
    word_t      wdata;
    logic [3:0] be;
    logic [2:0] f3;
    logic       wr_rd;
    logic       chk_addr;
    logic       exp_re;
    logic       exp_we;
    if (pc !== model_pc) begin
      check_value("pc", model_pc, pc);
      // Resync to the DUT after a wrong jump
      model_pc = pc;
    end
    f3 = inst[14:12];
    rs1v = regs[inst[19:15]];
    rs2v = regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    next_pc = model_pc + 32'd4;
    result = next_pc;
    exp_addr = '0;
    wr_rd = 1'b1;
    chk_addr = 1'b1;
    exp_re = 1'b0;
    exp_we = 1'b0;
    case (inst[6:0])
      `RV_OP_LUI:   exp_addr = {inst[31:12], 12'b0};
      `RV_OP_AUIPC: exp_addr = model_pc + {inst[31:12], 12'b0};
      `RV_OP_JAL: begin
        chk_addr = 1'b0;
        next_pc = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      `RV_OP_JALR: begin
        chk_addr = 1'b0;
        next_pc = (rs1v + imm_i) & ~32'd1;
      end
      `RV_OP_BRANCH: begin
        chk_addr = 1'b0;
        wr_rd = 1'b0;
        if (branch_taken(f3, rs1v, rs2v)) begin
          next_pc = model_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      `RV_OP_LOAD: begin
        exp_addr = rs1v + imm_i;
        exp_re = 1'b1;
        lane = mem[exp_addr[11:2]] >> {exp_addr[1:0], 3'b000};
        case (f3)
          3'b000:  result = {{24{lane[7]}}, lane[7:0]};
          3'b001:  result = {{16{lane[15]}}, lane[15:0]};
          3'b100:  result = {24'b0, lane[7:0]};
          3'b101:  result = {16'b0, lane[15:0]};
          default: result = lane;
        endcase
      end
      `RV_OP_STORE: begin
        exp_addr = rs1v + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        exp_we = 1'b1;
        wr_rd = 1'b0;
      end
      `RV_OP_IMM: exp_addr = alu_model(f3, inst[30] && f3 == 3'b101, rs1v, imm_i);
      `RV_OP_REG: exp_addr = alu_model(f3, inst[30], rs1v, rs2v);
      default: begin
        chk_addr = 1'b0;
        wr_rd = 1'b0;
      end
    endcase
    // ALU class writes its own result back
    if (chk_addr && !exp_re && !exp_we) begin
      result = exp_addr;
    end
    check_value("bus_req.read_enable", word_t'(exp_re), word_t'(bus_req.read_enable));
    check_value("bus_req.write_enable", word_t'(exp_we), word_t'(bus_req.write_enable));
    if (chk_addr) begin
      check_value("bus_req.address", exp_addr, bus_req.address);
    end
    if (exp_we) begin
      case (f3[1:0])
        2'b00: begin
          be = 4'b0001 << exp_addr[1:0];
          wdata = {4{rs2v[7:0]}};
        end
        2'b01: begin
          be = 4'b0011 << exp_addr[1:0];
          wdata = {2{rs2v[15:0]}};
        end
        default: begin
          be = 4'b1111;
          wdata = rs2v;
        end
      endcase
      check_value("bus_req.byte_enable", word_t'(be), word_t'(bus_req.byte_enable));
      check_value("bus_req.write_data", wdata, bus_req.write_data);
      mem[exp_addr[11:2]] = merge_lanes(mem[exp_addr[11:2]], wdata, be);
    end
    if (wr_rd && inst[11:7] != 5'd0) begin
      regs[inst[11:7]] = result;
    end
    model_pc = next_pc;
    executed++;
  endtask

  initial begin
    model_pc = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
      mem[i] = fill_word(i);
    end
  end

  // Mid-cycle, all DUT outputs settled
  always @(negedge clock) begin
    if (!rst_n) begin
      model_pc = `RV_RESET_PC;
      check_value("pc", `RV_RESET_PC, pc);
      check_value("bus_req.read_enable", '0, word_t'(bus_req.read_enable));
      check_value("bus_req.write_enable", '0, word_t'(bus_req.write_enable));
    end else begin
      step_model();
    end
  end

endmodule

//--- tb_riscv_core.sv
/*
 * Testbench top: clock and reset, random RV32I program image,
 * instruction and data memories, DUT and checker
 */
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module tb_riscv_core import rv_core_pkg::*; ();

  localparam int run_cycles = 3000;

  logic      clock = 1'b0;
  logic      rst_n;
  word_t     inst;
  word_t     bus_read_data;
  word_t     pc;
  dmem_req_t bus_req;
  word_t     imem [256];
  word_t     dmem [1024];
  word_t     rng;
  word_t     r1;
  int        errors;
  int        steps;
  int        timeouts;
  int        wait_cycles;

  function automatic word_t xorshift32(input word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Odd multiplier, so every address bit changes the word
  function automatic word_t fill_word(input int idx);
    return (word_t'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic word_t merge_lanes(input word_t old, input word_t data, input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        old[8*b +: 8] = data[8*b +: 8];
      end
    end
    return old;
  endfunction

  // One legal instruction, class picked from b, fields from a
  function automatic word_t random_inst(input word_t a, input word_t b);
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    f3 = a[14:12];
    imm = a[31:20];
    // Nonzero word multiples, no jump to self
    boff = {{3{b[9]}}, b[9:3], 3'b100};
    joff = {{11{b[9]}}, b[9:3], 3'b100};
    case (b[31:28] % 10)
      0: return {a[31:12], a[11:7], `RV_OP_LUI};
      1: return {a[31:12], a[11:7], `RV_OP_AUIPC};
      2: return {joff[20], joff[10:1], joff[11], joff[19:12], a[11:7], `RV_OP_JAL};
      3: return {imm, a[19:15], 3'b000, a[11:7], `RV_OP_JALR};
      4: begin
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;
        end
        return {boff[12], boff[10:5], a[24:20], a[19:15], f3, boff[4:1], boff[11],
                `RV_OP_BRANCH};
      end
      // Loads and stores use x0 as base with a size-aligned offset
      5: begin
        f3 = (f3[1:0] == 2'b11) ? 3'b010 : {f3[2] & ~f3[1], f3[1:0]};
        imm = imm & (12'hfff << f3[1:0]);
        return {imm, 5'd0, f3, a[11:7], `RV_OP_LOAD};
      end
      6: begin
        f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
        imm = imm & (12'hfff << f3[1:0]);
        return {imm[11:5], a[24:20], 5'd0, f3, imm[4:0], `RV_OP_STORE};
      end
      7, 8: begin
        if (f3[1:0] == 2'b01) begin
          imm = {1'b0, b[0] & f3[2], 5'b0, imm[4:0]};
        end
        return {imm, a[19:15], f3, a[11:7], `RV_OP_IMM};
      end
      default: return {1'b0, b[0] & (f3 == 3'b000 || f3 == 3'b101), 5'b0, a[24:20],
                       a[19:15], f3, a[11:7], `RV_OP_REG};
    endcase
  endfunction

  initial begin
    forever #2 clock = ~clock;
  end

  initial begin
    rng = 32'h6f29;
    for (int i = 0; i < 256; i++) begin
      rng = xorshift32(rng);
      r1 = rng;
      rng = xorshift32(rng);
      // Word 0 is a load, words 1..31 set x1..x31 from x0
      if (i == 0) begin
        imem[i] = {12'd0, 5'd0, 3'b010, 5'd0, `RV_OP_LOAD};
      end else if (i < 32) begin
        imem[i] = {r1[31:20], 5'd0, 3'b000, 5'(i), `RV_OP_IMM};
      end else begin
        imem[i] = random_inst(r1, rng);
      end
    end
    for (int i = 0; i < 1024; i++) begin
      dmem[i] = fill_word(i);
    end
  end

  assign inst          = imem[pc[9:2]];
  assign bus_read_data = dmem[bus_req.address[11:2]];

  always @(posedge clock) begin
    if (bus_req.write_enable) begin
      dmem[bus_req.address[11:2]] <= merge_lanes(dmem[bus_req.address[11:2]],
                                                 bus_req.write_data, bus_req.byte_enable);
    end
  end

  riscv_core dut_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .inst          (inst),
    .bus_read_data (bus_read_data),
    .pc            (pc),
    .bus_req       (bus_req)
  );

  tb_core_checker checker_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .inst    (inst),
    .pc      (pc),
    .bus_req (bus_req),
    .errors  (errors),
    .steps   (steps)
  );

  initial begin
    rst_n = 1'b0;
    timeouts = 0;
    repeat (4) @(posedge clock);
    // Reset PC shows a store for the rest of reset
    imem[0] <= {7'd0, 5'd0, 5'd0, 3'b010, 5'd0, `RV_OP_STORE};
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;
    wait_cycles = 0;
    while (pc === `RV_RESET_PC && wait_cycles < 16) begin
      @(negedge clock);
      wait_cycles++;
    end
    if (pc === `RV_RESET_PC) begin
      timeouts++;
      $display("Timeout: pc did not leave the reset address after reset release");
    end
    wait_cycles = 0;
    while (steps < run_cycles && wait_cycles < run_cycles + 100) begin
      @(negedge clock);
      wait_cycles++;
    end
    if (steps < run_cycles) begin
      timeouts++;
      $display("Timeout: checker stepped only %0d of %0d instructions", steps, run_cycles);
    end
    $display("Errors: %0d mismatches, %0d timeouts, %0d instructions checked",
             errors, timeouts, steps);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+.
rv_core_pkg.sv
rv_regfile.sv
rv_alu.sv
rv_datapath.sv
rv_ctlpath.sv
rv_dmem_interface.sv
riscv_core.sv
tb_core_checker.sv
tb_riscv_core.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_core_pkg.sv
      - rv_regfile.sv
      - rv_alu.sv
      - rv_datapath.sv
      - rv_ctlpath.sv
      - rv_dmem_interface.sv
      - riscv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core_checker.sv
      - tb_riscv_core.sv
